// File: project.f
+incdir+source
source/lsu_pkg.sv
source/mem_req_stage.sv
source/dcache_array.sv
source/dcache_ctrl.sv
source/mem_resp_stage.sv
source/lsu_top.sv
tests/apb_mem_model.sv
tests/lsu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the lsu testbench with verilator, run it, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    -f project.f \
    --top-module lsu_tb \
    -Mdir "$build_dir" \
    -o lsu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/lsu_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$log_file"; then
    exit 0
fi
echo "pass line not found in $log_file"
exit 1

// File: source/dcache_array.sv
`include "lsu_macros.svh"

module dcache_array (
    input  logic                 clk,
    input  logic                 arst_n,
    input  lsu_pkg::index_t      index,
    input  lsu_pkg::tag_t        tag,
    output logic                 hit,
    input  lsu_pkg::word_sel_t   rd_word_sel,
    output logic [`LSU_XLEN-1:0] rd_data,
    input  logic                 wr_en,
    input  lsu_pkg::index_t      wr_index,
    input  lsu_pkg::word_sel_t   wr_word_sel,
    input  logic [3:0]           wr_mask,
    input  logic [`LSU_XLEN-1:0] wr_data,
    input  logic                 fill_done,
    input  lsu_pkg::tag_t        fill_tag
);
    import lsu_pkg::*;

    logic [(1<<`LSU_INDEX_BITS)-1:0] valid_q;
    tag_t                            tag_mem  [1<<`LSU_INDEX_BITS];
    logic [`LSU_XLEN-1:0]            data_mem [1<<`LSU_INDEX_BITS][1<<`LSU_WORD_SEL_BITS];

    // combinational lookup
    assign hit     = valid_q[index] && (tag_mem[index] == tag);
    assign rd_data = data_mem[index][rd_word_sel];

    // valid bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (fill_done) begin
            // line complete, now it may hit
            valid_q[wr_index] <= 1'b1;
        end else if (wr_en && (tag_mem[wr_index] != fill_tag)) begin
            // refill over an old line drops it right away
            valid_q[wr_index] <= 1'b0;
        end
    end

    // tag written once the whole line is in
    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_mem[wr_index] <= fill_tag;
        end
    end

    // byte-masked word write, refill uses a full mask
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_mask[b]) begin
                    data_mem[wr_index][wr_word_sel][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // line completion comes with the last full refill word, never with a store
    fill_with_full_word_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        fill_done |-> (wr_en && (wr_mask == 4'hf))
    );

endmodule

// File: source/dcache_ctrl.sv
`include "lsu_macros.svh"

module dcache_ctrl (
    input  logic                 clk,
    input  logic                 arst_n,
    input  lsu_pkg::cache_req_t  cache_req,
    output lsu_pkg::index_t      index,
    output lsu_pkg::tag_t        tag,
    input  logic                 hit,
    output lsu_pkg::word_sel_t   rd_word_sel,
    input  logic [`LSU_XLEN-1:0] rd_data,
    output logic                 wr_en,
    output lsu_pkg::index_t      wr_index,
    output lsu_pkg::word_sel_t   wr_word_sel,
    output logic [3:0]           wr_mask,
    output logic [`LSU_XLEN-1:0] wr_data,
    output logic                 fill_done,
    output lsu_pkg::tag_t        fill_tag,
    output lsu_pkg::apb_req_t    apb,
    input  logic                 pready,
    input  logic [`LSU_XLEN-1:0] prdata,
    output logic                 stall,
    output logic                 done,
    output logic [`LSU_XLEN-1:0] done_data
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REFILL_SETUP,
        ST_REFILL_ACCESS,
        ST_STORE_SETUP,
        ST_STORE_ACCESS
    } state_e;

    state_e    state_q;
    state_e    state_d;
    word_sel_t cnt_q;
    logic      exc;
    logic      is_refill;
    logic      is_store;
    logic      xfer_end;

    assign exc       = cache_req.exp != EXC_NONE;
    assign is_refill = (state_q == ST_REFILL_SETUP) || (state_q == ST_REFILL_ACCESS);
    assign is_store  = (state_q == ST_STORE_SETUP) || (state_q == ST_STORE_ACCESS);
    // apb transfer completes on this edge
    assign xfer_end  = apb.penable && pready;

    // lookup always follows the current request
    assign index       = cache_req.addr.f.index;
    assign tag         = cache_req.addr.f.tag;
    assign rd_word_sel = cache_req.addr.f.word_sel;
    assign done_data   = rd_data;

    always_comb begin
        state_d = state_q;
        done    = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (cache_req.valid) begin
                    if (exc) begin
                        // no access at all
                        done = 1'b1;
                    end else if (cache_req.write) begin
                        state_d = ST_STORE_SETUP;
                    end else if (hit) begin
                        done = 1'b1;
                    end else begin
                        state_d = ST_REFILL_SETUP;
                    end
                end
            end
            ST_REFILL_SETUP: state_d = ST_REFILL_ACCESS;
            ST_REFILL_ACCESS: begin
                // back to idle after word 3 and the hit path answers
                if (pready) begin
                    state_d = (&cnt_q) ? ST_IDLE : ST_REFILL_SETUP;
                end
            end
            ST_STORE_SETUP: state_d = ST_STORE_ACCESS;
            ST_STORE_ACCESS: begin
                if (pready) begin
                    done    = 1'b1;
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // hold the pipe until this request completes
    assign stall = cache_req.valid && !done;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            // wraps to 0 after the last word
            if (is_refill && xfer_end) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // apb master outputs
    always_comb begin
        apb.psel    = state_q != ST_IDLE;
        apb.penable = (state_q == ST_REFILL_ACCESS) || (state_q == ST_STORE_ACCESS);
        apb.pwrite  = is_store;
        if (is_refill) begin
            apb.paddr  = {cache_req.addr.f.tag, cache_req.addr.f.index, cnt_q, 2'b00};
            apb.pwdata = '0;
            apb.pstrb  = 4'b0000;
        end else begin
            apb.paddr  = {cache_req.addr.word[`LSU_XLEN-1:2], 2'b00};
            apb.pwdata = is_store ? cache_req.wdata : '0;
            apb.pstrb  = is_store ? cache_req.be : 4'b0000;
        end
    end

    // refill words or a store that hits
    assign wr_en       = xfer_end && (is_refill || hit);
    assign wr_index    = cache_req.addr.f.index;
    assign wr_word_sel = is_refill ? cnt_q : cache_req.addr.f.word_sel;
    assign wr_mask     = is_refill ? 4'hf : cache_req.be;
    assign wr_data     = is_refill ? prdata : cache_req.wdata;
    assign fill_done   = xfer_end && is_refill && (&cnt_q);
    assign fill_tag    = cache_req.addr.f.tag;

    // psel held with a stable address until the transfer ends
    apb_psel_hold_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        (apb.psel && !xfer_end) |=> (apb.psel && $stable(apb.paddr))
    );

    // access phase lasts until pready with write data and strobes held
    apb_penable_hold_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        (apb.psel && !xfer_end) |=>
            (apb.penable && $stable(apb.pwdata) && $stable(apb.pstrb))
    );

endmodule

// File: source/lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// data and address width of the core
`define LSU_XLEN 32

// cache geometry
// 16 lines, direct mapped
`define LSU_INDEX_BITS 4

// 4 words per line
`define LSU_WORD_SEL_BITS 2

`endif

// File: source/lsu_pkg.sv
`include "lsu_macros.svh"

package lsu_pkg;

    // access width, same code the execute stage sends
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b10,
        MEM_WORD = 2'b11
    } mem_width_e;

    // exception field of the pipeline
    typedef enum logic [6:0] {
        EXC_NONE             = 7'd0,
        EXC_LOAD_MISALIGNED  = 7'd4,
        EXC_STORE_MISALIGNED = 7'd6
    } exc_code_e;

    // address slices as the cache sees them
    typedef logic [`LSU_XLEN-`LSU_INDEX_BITS-`LSU_WORD_SEL_BITS-3:0] tag_t;
    typedef logic [`LSU_INDEX_BITS-1:0]                             index_t;
    typedef logic [`LSU_WORD_SEL_BITS-1:0]                          word_sel_t;

    typedef struct packed {
        tag_t       tag;
        index_t     index;
        word_sel_t  word_sel;
        logic [1:0] byte_off;
    } cache_addr_fields_t;

    // same 32 bits, read as a flat address or as cache fields
    typedef union packed {
        logic [`LSU_XLEN-1:0] word;
        cache_addr_fields_t   f;
    } cache_addr_u;

    // request from execute
    typedef struct packed {
        logic                 valid;
        logic                 write;
        mem_width_e           width;
        logic                 is_signed;
        logic [4:0]           rd;
        logic [6:0]           exp;
        logic [`LSU_XLEN-1:0] base;
        logic [`LSU_XLEN-1:0] imm;
        logic [`LSU_XLEN-1:0] wdata;
    } mem_req_t;

    // aligned request into the cache
    typedef struct packed {
        logic                 valid;
        logic                 write;
        cache_addr_u          addr;
        logic [3:0]           be;
        logic [`LSU_XLEN-1:0] wdata;
        logic [4:0]           rd;
        mem_width_e           width;
        logic                 is_signed;
        logic [6:0]           exp;
    } cache_req_t;

    // result toward write-back
    typedef struct packed {
        logic                 valid;
        logic [4:0]           rd;
        logic [6:0]           exp;
        logic [`LSU_XLEN-1:0] data;
    } mem_wb_t;

    // apb master outputs
    typedef struct packed {
        logic                 psel;
        logic                 penable;
        logic                 pwrite;
        logic [`LSU_XLEN-1:0] paddr;
        logic [`LSU_XLEN-1:0] pwdata;
        logic [3:0]           pstrb;
    } apb_req_t;

endpackage

// File: source/lsu_top.sv
`include "lsu_macros.svh"

module lsu_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  lsu_pkg::mem_req_t    mem_req,
    output logic                 stall,
    output lsu_pkg::mem_wb_t     mem_wb,
    output lsu_pkg::apb_req_t    apb,
    input  logic                 pready,
    input  logic [`LSU_XLEN-1:0] prdata
);
    import lsu_pkg::*;

    // request stage to cache
    cache_req_t           cache_req;

    // controller to array
    index_t               index;
    tag_t                 tag;
    logic                 hit;
    word_sel_t            rd_word_sel;
    logic [`LSU_XLEN-1:0] rd_data;
    logic                 wr_en;
    index_t               wr_index;
    word_sel_t            wr_word_sel;
    logic [3:0]           wr_mask;
    logic [`LSU_XLEN-1:0] wr_data;
    logic                 fill_done;
    tag_t                 fill_tag;

    // completed access toward the response stage
    logic                 done;
    logic [`LSU_XLEN-1:0] done_data;

    mem_req_stage req_i (
        .mem_req   (mem_req),
        .cache_req (cache_req)
    );

    dcache_ctrl ctrl_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .cache_req   (cache_req),
        .index       (index),
        .tag         (tag),
        .hit         (hit),
        .rd_word_sel (rd_word_sel),
        .rd_data     (rd_data),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_word_sel (wr_word_sel),
        .wr_mask     (wr_mask),
        .wr_data     (wr_data),
        .fill_done   (fill_done),
        .fill_tag    (fill_tag),
        .apb         (apb),
        .pready      (pready),
        .prdata      (prdata),
        .stall       (stall),
        .done        (done),
        .done_data   (done_data)
    );

    dcache_array array_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .index       (index),
        .tag         (tag),
        .hit         (hit),
        .rd_word_sel (rd_word_sel),
        .rd_data     (rd_data),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_word_sel (wr_word_sel),
        .wr_mask     (wr_mask),
        .wr_data     (wr_data),
        .fill_done   (fill_done),
        .fill_tag    (fill_tag)
    );

    mem_resp_stage resp_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .done      (done),
        .done_data (done_data),
        .cache_req (cache_req),
        .mem_wb    (mem_wb)
    );

endmodule

// File: source/mem_req_stage.sv
module mem_req_stage (
    input  lsu_pkg::mem_req_t   mem_req,
    output lsu_pkg::cache_req_t cache_req
);
    import lsu_pkg::*;

    cache_addr_u addr;
    logic [1:0]  off;
    logic        misaligned;
    logic [3:0]  be;
    logic [31:0] lane_data;
    logic [6:0]  exp_out;

    // effective address
    assign addr.word = mem_req.base + mem_req.imm;
    assign off       = addr.f.byte_off;

    // byte enables and store lanes per width
    always_comb begin
        case (mem_req.width)
            MEM_BYTE: begin
                be         = 4'b0001 << off;
                lane_data  = {24'b0, mem_req.wdata[7:0]} << {off, 3'b000};
                misaligned = 1'b0;
            end
            MEM_HALF: begin
                be         = 4'b0011 << off;
                lane_data  = {16'b0, mem_req.wdata[15:0]} << {off, 3'b000};
                // half must sit on an even byte
                misaligned = off[0];
            end
            default: begin
                // unused code 01 treated as a word
                be         = 4'b1111;
                lane_data  = mem_req.wdata;
                misaligned = off != 2'b00;
            end
        endcase
    end

    // earlier exception wins over ours
    always_comb begin
        if (mem_req.exp != EXC_NONE) begin
            exp_out = mem_req.exp;
        end else if (misaligned) begin
            exp_out = mem_req.write ? EXC_STORE_MISALIGNED : EXC_LOAD_MISALIGNED;
        end else begin
            exp_out = EXC_NONE;
        end
    end

    always_comb begin
        cache_req.valid     = mem_req.valid;
        // no memory write once an exception is flagged
        cache_req.write     = mem_req.write && (exp_out == EXC_NONE);
        cache_req.addr      = addr;
        cache_req.be        = be;
        cache_req.wdata     = lane_data;
        cache_req.rd        = mem_req.rd;
        cache_req.width     = mem_req.width;
        cache_req.is_signed = mem_req.is_signed;
        cache_req.exp       = exp_out;
    end

endmodule

// File: source/mem_resp_stage.sv
`include "lsu_macros.svh"

module mem_resp_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 done,
    input  logic [`LSU_XLEN-1:0] done_data,
    input  lsu_pkg::cache_req_t  cache_req,
    output lsu_pkg::mem_wb_t     mem_wb
);
    import lsu_pkg::*;

    logic [`LSU_XLEN-1:0] lane;
    logic [`LSU_XLEN-1:0] load_data;
    logic                 valid_q;
    logic [4:0]           rd_q;
    logic [6:0]           exp_q;
    logic [`LSU_XLEN-1:0] data_q;

    // bring the addressed byte or half down to bit 0
    assign lane = done_data >> {cache_req.addr.f.byte_off, 3'b000};

    always_comb begin
        case (cache_req.width)
            MEM_BYTE: load_data = {{24{cache_req.is_signed & lane[7]}}, lane[7:0]};
            MEM_HALF: load_data = {{16{cache_req.is_signed & lane[15]}}, lane[15:0]};
            default:  load_data = done_data;
        endcase
        // stores and exceptions carry no data
        if (cache_req.write || (cache_req.exp != EXC_NONE)) begin
            load_data = '0;
        end
    end

    // one-cycle valid pulse
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= done;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            rd_q   <= cache_req.rd;
            exp_q  <= cache_req.exp;
            data_q <= load_data;
        end
    end

    always_comb begin
        mem_wb.valid = valid_q;
        mem_wb.rd    = rd_q;
        mem_wb.exp   = exp_q;
        mem_wb.data  = data_q;
    end

endmodule

// File: tests/apb_mem_model.sv
`include "lsu_macros.svh"

module apb_mem_model (
    input  logic                 clk,
    input  logic                 arst_n,
    input  lsu_pkg::apb_req_t    apb,
    output logic                 pready,
    output logic [`LSU_XLEN-1:0] prdata
);
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    localparam int MEM_BYTES = 1024;

    logic [7:0] mem [MEM_BYTES];
    logic [1:0] wait_q;
    logic [9:0] word_addr;

    // start content, every address bit matters
    function automatic logic [7:0] fill_byte(int a);
        return 8'(a) ^ {4{2'(a >> 8)}} ^ 8'h5a;
    endfunction

    // only 1 KiB decoded, word aligned
    assign word_addr = {apb.paddr[9:2], 2'b00};

    // ready once the wait states of this transfer ran out
    assign pready = apb.penable && (wait_q == 2'd0);
    assign prdata = {mem[word_addr + 10'd3], mem[word_addr + 10'd2],
                     mem[word_addr + 10'd1], mem[word_addr]};

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_q <= 2'd0;
            for (int a = 0; a < MEM_BYTES; a++) begin
                mem[a] <= fill_byte(a);
            end
        end else begin
            // pick 0 to 3 wait states in the setup cycle
            if (apb.psel && !apb.penable) begin
                wait_q <= 2'($urandom_range(0, 3));
            end else if (apb.penable && (wait_q != 2'd0)) begin
                wait_q <= wait_q - 2'd1;
            end
            // byte strobes on write completion
            if (apb.psel && apb.penable && pready && apb.pwrite) begin
                for (int b = 0; b < 4; b++) begin
                    if (apb.pstrb[b]) begin
                        mem[word_addr + 10'(b)] <= apb.pwdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: tests/lsu_tb.sv
`include "lsu_macros.svh"

module lsu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    localparam int NUM_REQ        = 400;
    localparam int CYCLES_PER_REQ = 40;
    localparam int MAX_CYCLES     = NUM_REQ * CYCLES_PER_REQ;
    localparam int MEM_BYTES      = 1024;
    localparam int LINES          = 1 << `LSU_INDEX_BITS;
    localparam int LINE_BYTES     = 4 << `LSU_WORD_SEL_BITS;

    logic                 clk;
    logic                 arst_n;
    mem_req_t             mem_req;
    logic                 stall;
    mem_wb_t              mem_wb;
    apb_req_t             apb;
    logic                 pready;
    logic [`LSU_XLEN-1:0] prdata;

    // reference memory and expected cache tags
    logic [7:0] ref_mem [MEM_BYTES];
    logic       line_valid [LINES];
    int         line_tag [LINES];
    int         last_addr;

    // bus transfers since the current request went out
    logic [31:0] rd_addr_q [$];
    int          wr_count;
    logic [31:0] wr_addr;
    logic [3:0]  wr_strb;
    logic [31:0] wr_data;

    int errors;
    int checks;
    int cycles;

    lsu_top dut_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .mem_req (mem_req),
        .stall   (stall),
        .mem_wb  (mem_wb),
        .apb     (apb),
        .pready  (pready),
        .prdata  (prdata)
    );

    apb_mem_model mem_i (
        .clk    (clk),
        .arst_n (arst_n),
        .apb    (apb),
        .pready (pready),
        .prdata (prdata)
    );

    always #4 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, request flow stuck", MAX_CYCLES);
            $display("checks %0d, errors %0d", checks, errors);
            $display("Simulation failed");
            $finish;
        end
    end

    // a transfer whose last cycle is this one ends on the next edge
    always @(negedge clk) begin
        if (apb.psel && apb.penable && pready) begin
            if (apb.pwrite) begin
                wr_count = wr_count + 1;
                wr_addr  = apb.paddr;
                wr_strb  = apb.pstrb;
                wr_data  = apb.pwdata;
            end else begin
                rd_addr_q.push_back(apb.paddr);
            end
        end
    end

    task automatic check_value(string name, logic [31:0] got, logic [31:0] want);
        checks = checks + 1;
        assert (got === want) else begin
            errors = errors + 1;
            $display("error: %s got %h expected %h", name, got, want);
        end
    endtask

    // memory model start content
    function automatic logic [7:0] fill_byte(int a);
        return 8'(a) ^ {4{2'(a >> 8)}} ^ 8'h5a;
    endfunction

    // one strobe per byte the access covers
    function automatic logic [3:0] expect_strb(mem_width_e width, logic [1:0] off);
        int         size;
        logic [3:0] strb;
        case (width)
            MEM_BYTE: size = 1;
            MEM_HALF: size = 2;
            default:  size = 4;
        endcase
        for (int b = 0; b < 4; b++) begin
            strb[b] = (b >= int'(off)) && (b < int'(off) + size);
        end
        return strb;
    endfunction

    // store data repeated over every lane so the strobes pick the live ones
    function automatic logic [31:0] store_lanes(mem_width_e width, logic [31:0] wdata);
        case (width)
            MEM_BYTE: return {4{wdata[7:0]}};
            MEM_HALF: return {2{wdata[15:0]}};
            default:  return wdata;
        endcase
    endfunction

    function automatic logic [31:0] byte_mask(logic [3:0] strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    function automatic logic [31:0] expect_load(int addr, mem_width_e width, logic sgn);
        case (width)
            MEM_BYTE: return {{24{sgn & ref_mem[addr][7]}}, ref_mem[addr]};
            MEM_HALF: return {{16{sgn & ref_mem[addr + 1][7]}}, ref_mem[addr + 1], ref_mem[addr]};
            default:  return {ref_mem[addr + 3], ref_mem[addr + 2],
                              ref_mem[addr + 1], ref_mem[addr]};
        endcase
    endfunction

    // one random request from edge+1 until its mem_wb pulse is gone
    task automatic run_request();
        int          addr;
        int          line_no;
        int          idx;
        int          tg;
        mem_width_e  width;
        logic        write;
        logic        sgn;
        logic        misalign;
        logic        hit_expected;
        logic        stall_seen;
        logic [4:0]  rd;
        logic [6:0]  exp_in;
        logic [6:0]  exp_code;
        logic [31:0] imm;
        logic [31:0] wdata;
        logic [31:0] lanes;
        logic [3:0]  strb;

        case ($urandom_range(0, 2))
            0:       width = MEM_BYTE;
            1:       width = MEM_HALF;
            default: width = MEM_WORD;
        endcase
        write    = $urandom_range(0, 99) < 40;
        sgn      = 1'($urandom_range(0, 1));
        misalign = $urandom_range(0, 99) < 10;
        rd       = 5'($urandom_range(0, 31));
        wdata    = $urandom();
        imm      = 32'($urandom_range(0, 255)) - 32'd128;
        // a few requests arrive with an earlier exception
        exp_in   = ($urandom_range(0, 99) < 3) ? 7'($urandom_range(1, 127)) : 7'd0;

        // half the time stay on the last line so repeats hit
        if ($urandom_range(0, 1) == 1) begin
            addr = last_addr / LINE_BYTES * LINE_BYTES + int'($urandom_range(0, LINE_BYTES - 1));
        end else begin
            addr = int'($urandom_range(0, MEM_BYTES - 1));
        end
        // bytes are never misaligned
        if (misalign && (width == MEM_BYTE)) begin
            width = MEM_HALF;
        end
        if (width == MEM_HALF) begin
            addr = misalign ? (addr | 1) : (addr & ~1);
        end else if (width == MEM_WORD) begin
            addr = addr & ~3;
            if (misalign) begin
                addr = addr + int'($urandom_range(1, 3));
            end
        end

        if (exp_in != 7'd0) begin
            exp_code = exp_in;
        end else if (misalign) begin
            exp_code = write ? EXC_STORE_MISALIGNED : EXC_LOAD_MISALIGNED;
        end else begin
            exp_code = EXC_NONE;
        end

        line_no      = addr / LINE_BYTES;
        idx          = line_no % LINES;
        tg           = line_no / LINES;
        hit_expected = line_valid[idx] && (line_tag[idx] == tg);
        strb         = expect_strb(width, 2'(addr % 4));
        lanes        = store_lanes(width, wdata);

        rd_addr_q.delete();
        wr_count          = 0;
        mem_req.valid     = 1'b1;
        mem_req.write     = write;
        mem_req.width     = width;
        mem_req.is_signed = sgn;
        mem_req.rd        = rd;
        mem_req.exp       = exp_in;
        mem_req.imm       = imm;
        mem_req.base      = 32'(addr) - imm;
        mem_req.wdata     = wdata;

        // held unchanged while stalled
        stall_seen = 1'b0;
        @(negedge clk);
        while (stall) begin
            stall_seen = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        mem_req.valid = 1'b0;
        @(negedge clk);

        check_value("mem_wb.valid", 32'(mem_wb.valid), 32'd1);
        check_value("mem_wb.rd", 32'(mem_wb.rd), 32'(rd));
        check_value("mem_wb.exp", 32'(mem_wb.exp), 32'(exp_code));

        if (exp_code != 7'd0) begin
            // nothing reaches the bus
            check_value("mem_wb.data", mem_wb.data, 32'd0);
            check_value("apb read count", 32'(rd_addr_q.size()), 32'd0);
            check_value("apb write count", 32'(wr_count), 32'd0);
            check_value("stall", 32'(stall_seen), 32'd0);
        end else if (write) begin
            check_value("mem_wb.data", mem_wb.data, 32'd0);
            check_value("apb read count", 32'(rd_addr_q.size()), 32'd0);
            check_value("apb write count", 32'(wr_count), 32'd1);
            check_value("stall", 32'(stall_seen), 32'd1);
            check_value("paddr", wr_addr, 32'(addr & ~3));
            check_value("pstrb", 32'(wr_strb), 32'(strb));
            check_value("pwdata", wr_data & byte_mask(strb), lanes & byte_mask(strb));
            // write-through so memory takes the enabled bytes
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    ref_mem[(addr & ~3) + b] = lanes[8*b +: 8];
                end
            end
        end else begin
            check_value("mem_wb.data", mem_wb.data, expect_load(addr, width, sgn));
            check_value("apb write count", 32'(wr_count), 32'd0);
            if (hit_expected) begin
                check_value("apb read count", 32'(rd_addr_q.size()), 32'd0);
                check_value("stall", 32'(stall_seen), 32'd0);
            end else begin
                // whole line in order from word 0
                check_value("apb read count", 32'(rd_addr_q.size()), 32'd4);
                check_value("stall", 32'(stall_seen), 32'd1);
                for (int k = 0; k < rd_addr_q.size(); k++) begin
                    check_value("paddr", rd_addr_q[k], 32'(line_no * LINE_BYTES + 4 * k));
                end
                line_valid[idx] = 1'b1;
                line_tag[idx]   = tg;
            end
        end

        // single cycle pulse
        @(negedge clk);
        check_value("mem_wb.valid", 32'(mem_wb.valid), 32'd0);
        last_addr = addr;
    endtask

    initial begin
        void'($urandom(76012));
        clk       = 1'b0;
        arst_n    = 1'b0;
        mem_req   = '0;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        wr_count  = 0;
        wr_addr   = '0;
        wr_strb   = '0;
        wr_data   = '0;
        last_addr = 0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            ref_mem[a] = fill_byte(a);
        end
        for (int i = 0; i < LINES; i++) begin
            line_valid[i] = 1'b0;
            line_tag[i]   = 0;
        end

        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // idle state out of reset
        @(negedge clk);
        check_value("stall", 32'(stall), 32'd0);
        check_value("mem_wb.valid", 32'(mem_wb.valid), 32'd0);
        check_value("psel", 32'(apb.psel), 32'd0);
        check_value("penable", 32'(apb.penable), 32'd0);

        for (int n = 0; n < NUM_REQ; n++) begin
            @(posedge clk);
            #1;
            run_request();
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
